/* dmem_pkg.sv */
//////////////////////////////////////////////////
// Widths, size and protection codes and the
// struct types shared by the data memory access
// controller. Import with dmem_pkg::* in a module header
//////////////////////////////////////////////////

package dmem_pkg;

  // Data and address widths
  localparam int XLEN = 32;
  localparam int PLEN = 32;

  // Request buffer geometry
  localparam int MEMBUF_DEPTH = 2;
  localparam int MEMBUF_PTR_W = $clog2(MEMBUF_DEPTH);
  localparam int MEMBUF_CNT_W = $clog2(MEMBUF_DEPTH + 1);

  localparam int PMA_CNT = 4;                       // Attribute regions

  // Transfer size codes
  localparam logic [2:0] SIZE_BYTE = 3'd0;
  localparam logic [2:0] SIZE_HALF = 3'd1;
  localparam logic [2:0] SIZE_WORD = 3'd2;

  // Bus protection bits, OR-ed together
  localparam logic [2:0] PROT_DATA       = 3'b001;
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010;
  localparam logic [2:0] PROT_USER       = 3'b000;

  // Privilege levels
  localparam logic [1:0] PRV_U = 2'd0;
  localparam logic [1:0] PRV_M = 2'd3;

  //////////////////////////////////////////////////
  // Struct types
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [PLEN-1:0] base;                          // Inclusive
    logic [PLEN-1:0] top;                           // Inclusive
    logic            valid;
    logic            writable;
  } pma_region_t;

  typedef struct packed {
    logic [PLEN-1:0] adr;
    logic [2:0]      size;
    logic            lock;
    logic            we;
    logic [XLEN-1:0] data;                          // Store data
  } dmem_req_t;

  typedef struct packed {
    logic       misaligned;
    logic       access_err;                         // Unmapped or read-only store
    logic [2:0] prot;
  } dmem_dec_t;

  typedef struct packed {
    logic [PLEN-1:0] adr;
    logic [2:0]      size;
    logic            we;
    logic            lock;
    logic [2:0]      prot;
    logic [XLEN-1:0] data;
  } bus_req_t;

  typedef struct packed {
    logic [XLEN-1:0] q;
    logic            err;
  } bus_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] q;                             // Raw bus word
    logic            err;
    logic            misaligned;
    logic [2:0]      size;
    logic [1:0]      adr_lo;                        // Byte lane select
  } dmem_cpl_t;

  typedef struct packed {
    logic [XLEN-1:0] q;
    logic            err;
    logic            misaligned;
  } dmem_rsp_t;

endpackage

/* dmem_membuf.sv */
//////////////////////////////////////////////////
// Request buffer between the CPU and the decode
// stage. Small circular FIFO, emptied by clr_i
// when a request fails
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_membuf
  import dmem_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      clr_i,          // Flush all entries
  input  logic      push_i,         // CPU request valid
  input  dmem_req_t d_i,
  input  logic      pop_i,
  output dmem_req_t q_o,            // Head entry
  output logic      valid_o,        // Not empty
  output logic      ready_o         // Room and no flush
);

  dmem_req_t               mem [MEMBUF_DEPTH];
  logic [MEMBUF_PTR_W-1:0] wr_ptr;
  logic [MEMBUF_PTR_W-1:0] rd_ptr;
  logic [MEMBUF_CNT_W-1:0] cnt;
  logic                    do_push;
  logic                    do_pop;

  // Nothing enters while a flush is applied
  assign ready_o = (cnt != MEMBUF_CNT_W'(MEMBUF_DEPTH)) && !clr_i;
  assign valid_o = (cnt != '0);
  assign do_push = push_i & ready_o;
  assign do_pop  = pop_i & valid_o;
  assign q_o     = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= d_i;
  end

  // Pointers and fill count
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (clr_i) begin
      wr_ptr <= '0;                 // Drop everything queued
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == MEMBUF_PTR_W'(MEMBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == MEMBUF_PTR_W'(MEMBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;        // Both or neither
      endcase
    end
  end

endmodule

/* dmem_decode.sv */
//////////////////////////////////////////////////
// Classifies the head request. Alignment check,
// attribute region lookup and bus protection
// bits, all combinational
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_decode
  import dmem_pkg::*;
(
  input  dmem_req_t                  req_i,
  input  logic [1:0]                 prv_i,   // Current privilege
  input  pma_region_t [PMA_CNT-1:0]  pma_i,   // Region table
  output dmem_dec_t                  dec_o
);

  logic misaligned;
  logic region_hit;
  logic region_wr;

  //////////////////////////////////////////////////
  // Misalignment
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.size)
      SIZE_HALF: misaligned = req_i.adr[0];
      SIZE_WORD: misaligned = |req_i.adr[1:0];
      default:   misaligned = 1'b0;           // Bytes always aligned
    endcase
  end

  //////////////////////////////////////////////////
  // Region lookup
  //////////////////////////////////////////////////

  // Walk from the top down so the lowest match wins
  always_comb begin
    region_hit = 1'b0;
    region_wr  = 1'b0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (pma_i[i].valid &&
          (req_i.adr >= pma_i[i].base) &&
          (req_i.adr <= pma_i[i].top)) begin
        region_hit = 1'b1;
        region_wr  = pma_i[i].writable;
      end
    end
  end

  // Result
  always_comb begin
    dec_o.misaligned = misaligned;
    // Unmapped, or store into read-only space
    dec_o.access_err = !region_hit || (req_i.we && !region_wr);
    dec_o.prot       = PROT_DATA |
                       ((prv_i == PRV_U) ? PROT_USER : PROT_PRIVILEGED);
  end

endmodule

/* dmem_bus_access.sv */
//////////////////////////////////////////////////
// Sequencer for the external bus. Pops the head
// request, fails it at once or runs one bus
// transfer, and reports a completion per request
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_bus_access
  import dmem_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      head_valid_i,
  input  dmem_req_t head_i,
  input  dmem_dec_t dec_i,
  output logic      pop_o,
  output logic      clr_o,          // Flush request buffer
  output logic      bus_req_valid_o,
  input  logic      bus_req_ready_i,
  output bus_req_t  bus_req_o,
  input  logic      bus_rsp_valid_i,
  input  bus_rsp_t  bus_rsp_i,
  output logic      cpl_valid_o,
  output dmem_cpl_t cpl_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,                         // Request on the bus
    ST_WAIT                         // Waiting for the response
  } state_t;

  state_t   state_q;
  state_t   state_d;
  bus_req_t bus_req_q;
  logic     fail;
  logic     start;

  assign fail            = dec_i.misaligned | dec_i.access_err;
  assign start           = (state_q == ST_IDLE) & head_valid_i;
  assign pop_o           = start;
  assign bus_req_valid_o = (state_q == ST_REQ);
  assign bus_req_o       = bus_req_q;                 // Held until handshake

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (start && !fail) state_d = ST_REQ;
      ST_REQ:  if (bus_req_ready_i) state_d = ST_WAIT;
      ST_WAIT: if (bus_rsp_valid_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= ST_IDLE;
    else           state_q <= state_d;
  end

  // Latch the transfer when a legal request leaves the buffer
  always_ff @(posedge clk_i) begin
    if (start && !fail) begin
      bus_req_q.adr  <= head_i.adr;
      bus_req_q.size <= head_i.size;
      bus_req_q.we   <= head_i.we;
      bus_req_q.lock <= head_i.lock;
      bus_req_q.prot <= dec_i.prot;
      bus_req_q.data <= head_i.data;
    end
  end

  //////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////

  always_comb begin
    cpl_o.q = bus_rsp_i.q;
    if (state_q == ST_WAIT) begin
      cpl_valid_o      = bus_rsp_valid_i;
      cpl_o.err        = bus_rsp_i.err;              // Bus error passes through
      cpl_o.misaligned = 1'b0;
      cpl_o.size       = bus_req_q.size;
      cpl_o.adr_lo     = bus_req_q.adr[1:0];
    end else begin
      cpl_valid_o      = start & fail;               // Same cycle, no transfer
      cpl_o.err        = dec_i.access_err;
      cpl_o.misaligned = dec_i.misaligned;
      cpl_o.size       = head_i.size;
      cpl_o.adr_lo     = head_i.adr[1:0];
    end
  end

  // Any failure drops the requests queued behind it
  assign clr_o = cpl_valid_o & (cpl_o.err | cpl_o.misaligned);

endmodule

/* dmem_result.sv */
//////////////////////////////////////////////////
// Turns each completion into a one-cycle CPU
// response. Sub-word loads are lane-shifted and
// zero-extended
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_result
  import dmem_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      cpl_valid_i,
  input  dmem_cpl_t cpl_i,
  output logic      rsp_valid_o,
  output dmem_rsp_t rsp_o
);

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] load_q;

  // Addressed lane down to bit 0
  assign shifted = cpl_i.q >> {cpl_i.adr_lo, 3'b000};

  always_comb begin
    case (cpl_i.size)
      SIZE_BYTE: load_q = {{(XLEN-8){1'b0}}, shifted[7:0]};
      SIZE_HALF: load_q = {{(XLEN-16){1'b0}}, shifted[15:0]};
      default:   load_q = cpl_i.q;                   // Full word
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) rsp_valid_o <= 1'b0;
    else           rsp_valid_o <= cpl_valid_i;
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (cpl_valid_i) begin
      rsp_o.q          <= load_q;
      rsp_o.err        <= cpl_i.err;
      rsp_o.misaligned <= cpl_i.misaligned;
    end
  end

endmodule

/* dmem_ctrl.sv */
//////////////////////////////////////////////////
// Data memory access controller top. CPU
// requests in, one bus transfer per legal request,
// one in-order response per request
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dmem_ctrl
  import dmem_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  pma_region_t [PMA_CNT-1:0] pma_i,
  input  logic [1:0]                prv_i,
  // CPU side
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  dmem_req_t                 req_i,
  output logic                      rsp_valid_o,
  output dmem_rsp_t                 rsp_o,
  // External bus
  output logic                      bus_req_valid_o,
  input  logic                      bus_req_ready_i,
  output bus_req_t                  bus_req_o,
  input  logic                      bus_rsp_valid_i,
  input  bus_rsp_t                  bus_rsp_i
);

  dmem_req_t head;
  logic      head_valid;
  dmem_dec_t dec;
  logic      pop;
  logic      clr;
  logic      cpl_valid;
  dmem_cpl_t cpl;

  dmem_membuf u_membuf (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clr_i    (clr),
    .push_i   (req_valid_i),
    .d_i      (req_i),
    .pop_i    (pop),
    .q_o      (head),
    .valid_o  (head_valid),
    .ready_o  (req_ready_o)
  );

  dmem_decode u_decode (
    .req_i (head),
    .prv_i (prv_i),
    .pma_i (pma_i),
    .dec_o (dec)
  );

  dmem_bus_access u_bus_access (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .head_valid_i    (head_valid),
    .head_i          (head),
    .dec_i           (dec),
    .pop_o           (pop),
    .clr_o           (clr),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_req_o       (bus_req_o),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_i       (bus_rsp_i),
    .cpl_valid_o     (cpl_valid),
    .cpl_o           (cpl)
  );

  dmem_result u_result (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cpl_valid_i (cpl_valid),
    .cpl_i       (cpl),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

/* tb_dmem_ctrl.sv */
//////////////////////////////////////////////////
// Testbench for the data memory access controller.
// LFSR-driven CPU requests, a bus responder and an
// in-order reference model with per-test checks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dmem_ctrl;
  import dmem_pkg::*;

  localparam int N_REQ = 40;                       // Requests per test
  localparam int N_TESTS = 5;
  localparam int CYC_LIMIT = 12 * N_REQ * N_TESTS + 200;

  typedef struct {
    dmem_req_t  req;
    logic       mis;
    logic       acc;
    logic [1:0] prv;
    logic       idle;                              // Accepted into an idle controller
    int         acc_cyc;
    logic       bus_seen;
  } exp_t;

  logic clk_i = 1'b0;
  logic arst_n_i;
  pma_region_t [PMA_CNT-1:0] pma_i;
  logic [1:0] prv_i;
  logic req_valid_i, req_ready_o, rsp_valid_o;
  dmem_req_t req_i;
  dmem_rsp_t rsp_o;
  logic bus_req_valid_o, bus_req_ready_i, bus_rsp_valid_i;
  bus_req_t bus_req_o, held;
  bus_rsp_t bus_rsp_i;

  logic [31:0] lfsr = 32'h8226;
  exp_t   exp_q[$];
  exp_t   e;
  logic   exp_err;
  string  test_name = "reset";
  int     cyc = 0, errors = 0, ready_low = 0, n_acc = 0;
  int     tests_run = 0, tests_failed = 0, dly = 0;
  logic   bp_on = 1'b0, hold_pending = 1'b0, rsp_pend = 1'b0;
  logic [31:0] rsp_adr;

  dmem_ctrl u_dut (.*);

  always #50 clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Responder word, lane-shifted and zero-extended as a load sees it
  function automatic logic [31:0] load_word(input logic [31:0] adr, input logic [2:0] size);
    logic [31:0] w;
    w = adr ^ 32'hA5A5_0F0F;
    if (size == 3'd0) return (w >> (8 * adr[1:0])) & 32'hFF;
    if (size == 3'd1) return (w >> (8 * adr[1:0])) & 32'hFFFF;
    return w;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Error %s %s: expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // Reference model and checks, response first at each edge
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      cyc++;
      // Buffer full while the bus stalls
      if (bus_req_valid_o && !bus_req_ready_i) begin
        check_val("req_ready", 32'(exp_q.size() < 3), 32'(req_ready_o));
        if (!req_ready_o) ready_low++;
      end
      if (rsp_valid_o) begin
        assert (exp_q.size() != 0) else begin
          $display("Response in test %s with no request waiting", test_name);
          errors++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          exp_err = e.acc | (!e.mis && !e.acc && e.req.adr[7:4] == 4'hF);
          check_val("misaligned", 32'(e.mis), 32'(rsp_o.misaligned));
          check_val("err", 32'(exp_err), 32'(rsp_o.err));
          check_val("bus request seen", 32'(!e.mis && !e.acc), 32'(e.bus_seen));
          if (!e.mis && !exp_err && !e.req.we)
            check_val("load data", load_word(e.req.adr, e.req.size), rsp_o.q);
          if (e.idle && (e.mis || e.acc)) check_val("latency", 2, cyc - e.acc_cyc);
          if (e.mis || exp_err) exp_q.delete();   // Queued ones dropped
        end
      end
      // Payload frozen while the bus stalls
      if (hold_pending) begin
        assert (bus_req_valid_o && (bus_req_o === held)) else begin
          $display("Error %s held bus request: expected %h actual %h",
                   test_name, held, bus_req_o);
          errors++;
        end
      end
      hold_pending <= bus_req_valid_o && !bus_req_ready_i;
      held         <= bus_req_o;
      if (bus_req_valid_o && bus_req_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Bus request in test %s with no request waiting", test_name);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_q[0].bus_seen = 1'b1;
          check_val("bus adr", exp_q[0].req.adr, bus_req_o.adr);
          check_val("bus size", 32'(exp_q[0].req.size), 32'(bus_req_o.size));
          check_val("bus we", 32'(exp_q[0].req.we), 32'(bus_req_o.we));
          check_val("bus lock", 32'(exp_q[0].req.lock), 32'(bus_req_o.lock));
          check_val("bus data", exp_q[0].req.data, bus_req_o.data);
          check_val("bus prot",
                    32'((exp_q[0].prv == PRV_U) ? 3'b001 : 3'b011),
                    32'(bus_req_o.prot));
        end
      end
      if (req_valid_i && req_ready_o) begin
        e.req = req_i;
        e.mis = (req_i.size == SIZE_HALF) ? req_i.adr[0] :
                (req_i.size == SIZE_WORD) ? |req_i.adr[1:0] : 1'b0;
        // Regions 0 to 2 writable, region 3 read-only
        e.acc = 1'b1;
        for (int i = 3; i >= 0; i--)
          if (req_i.adr >= pma_i[i].base && req_i.adr <= pma_i[i].top)
            e.acc = req_i.we && (i == 3);
        e.prv = prv_i;
        e.idle = (exp_q.size() == 0);
        e.acc_cyc = cyc;
        e.bus_seen = 1'b0;
        exp_q.push_back(e);
        n_acc++;
      end
    end
  end

  // Watchdog on the cycle count
  always @(negedge clk_i) begin
    assert (cyc < CYC_LIMIT) else begin
      $display("Timeout after %0d cycles in test %s", cyc, test_name);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Bus responder with random ready and delay
  always @(posedge clk_i) begin
    bus_req_ready_i <= bp_on ? 1'(rand_bits(1)) : 1'b1;
    bus_rsp_valid_i <= 1'b0;
    if (bus_req_valid_o && bus_req_ready_i) begin
      rsp_pend = 1'b1;
      dly = rand_bits(2);
      rsp_adr = bus_req_o.adr;
    end else if (rsp_pend) begin
      if (dly == 0) begin
        rsp_pend = 1'b0;
        bus_rsp_valid_i <= 1'b1;
        bus_rsp_i.q     <= rsp_adr ^ 32'hA5A5_0F0F;
        bus_rsp_i.err   <= (rsp_adr[7:4] == 4'hF);
      end else dly--;
    end
  end

  // Modes: 0 loads, 1 stores, 2 misaligned or unmapped, 3 bus errors, 4 back-pressure
  task automatic run_test(input string name, input int mode);
    int start_err, start_acc;
    logic [31:0] adr;
    logic [2:0] size;
    logic [1:0] r;
    start_err = errors;
    start_acc = n_acc;
    test_name = name;
    bp_on = (mode == 4);
    @(posedge clk_i);
    prv_i <= rand_bits(1) ? PRV_M : PRV_U;
    while (n_acc - start_acc < N_REQ) begin
      @(posedge clk_i);
      if (!req_valid_i || req_ready_o) begin
        r = 2'(rand_bits(2));
        size = (rand_bits(2) == 0) ? SIZE_BYTE : (rand_bits(1) ? SIZE_HALF : SIZE_WORD);
        adr = {20'h0, r[0], 11'(rand_bits(11))};         // Offset inside a region
        adr[17:16] = (r == 2'd2) ? 2'd1 : (r == 2'd3) ? 2'd2 : 2'd0;
        adr[13] = (r == 2'd1);
        if (mode == 2 && rand_bits(2) == 0) adr[12] = 1'b1;   // Into a gap
        if (mode != 2 || rand_bits(1)) begin
          if (size == SIZE_HALF) adr[0] = 1'b0;
          if (size == SIZE_WORD) adr[1:0] = 2'b00;
        end
        adr[7] = 1'b0;
        if (mode == 3 && rand_bits(1)) adr[7:4] = 4'hF;
        req_i.adr  <= adr;
        req_i.size <= size;
        req_i.we   <= (mode == 0) ? 1'b0 : (mode == 1) ? 1'b1 : 1'(rand_bits(1));
        req_i.lock <= 1'(rand_bits(1));
        req_i.data <= rand_bits(32);
        req_valid_i <= (mode == 2) ? (rand_bits(2) == 0) : 1'(rand_bits(1));
      end
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    while (exp_q.size() != 0 || bus_req_valid_o) @(negedge clk_i);
    repeat (3) @(posedge clk_i);
    if (mode == 4) begin
      assert (ready_low > 0) else begin
        $display("Request ready never fell under back-pressure");
        errors++;
      end
    end
    tests_run++;
    if (errors != start_err) tests_failed++;
    $display("Test %s: %0d errors", name, errors - start_err);
  endtask

  initial begin
    arst_n_i = 1'b0;
    prv_i = PRV_M;
    req_valid_i = 1'b0;
    req_i = '0;
    bus_req_ready_i = 1'b1;
    bus_rsp_valid_i = 1'b0;
    bus_rsp_i = '0;
    pma_i[0] = '{base: 32'h0000_0000, top: 32'h0000_0FFF, valid: 1'b1, writable: 1'b1};
    pma_i[1] = '{base: 32'h0000_2000, top: 32'h0000_2FFF, valid: 1'b1, writable: 1'b1};
    pma_i[2] = '{base: 32'h0001_0000, top: 32'h0001_0FFF, valid: 1'b1, writable: 1'b1};
    pma_i[3] = '{base: 32'h0002_0000, top: 32'h0002_0FFF, valid: 1'b1, writable: 1'b0};
    for (int i = 0; i < 17; i++) begin
      @(posedge clk_i);
      check_val("rsp_valid", 0, 32'(rsp_valid_o));
      check_val("bus_req_valid", 0, 32'(bus_req_valid_o));
      check_val("req_ready", 1, 32'(req_ready_o));
      if (i == 15) arst_n_i <= 1'b1;                 // Release after 16 cycles
    end
    tests_run++;
    if (errors != 0) tests_failed++;
    $display("Test reset: %0d errors", errors);
    run_test("loads", 0);
    run_test("stores", 1);
    run_test("misaligned_unmapped", 2);
    run_test("bus_errors", 3);
    run_test("back_pressure", 4);
    $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
dmem_pkg.sv
dmem_membuf.sv
dmem_decode.sv
dmem_bus_access.sv
dmem_result.sv
dmem_ctrl.sv
tb_dmem_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dmem_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
